// File: compile.f
+incdir+hw
hw/stepper_pkg.sv
hw/spi_ctrl_if.sv
hw/step_ctrl_if.sv
hw/periph_regs.sv
hw/spi_master.sv
hw/step_generator.sv
hw/stepper_top.sv
tests/tb_stepper.sv

// File: Bender.yml
package:
  name: stepper_periph

export_include_dirs:
  - hw

sources:
  - files:
      - hw/stepper_pkg.sv
      - hw/spi_ctrl_if.sv
      - hw/step_ctrl_if.sv
      - hw/periph_regs.sv
      - hw/spi_master.sv
      - hw/step_generator.sv
      - hw/stepper_top.sv
  - target: test
    files:
      - tests/tb_stepper.sv

// File: tests/tb_stepper.sv
/* tb_stepper: testbench for the stepper peripheral subsystem
   register access, SPI loopback, step runs and driver enables */
`include "stepper_cfg.svh"

module tb_stepper;
  import stepper_pkg::*;

  localparam int max_cycles = 20000;
  localparam int max_polls  = 400;

  logic                      clk_in;
  logic                      arst_n;
  logic                      mem_valid;
  logic [`BUS_ADDR_BITS-1:0] mem_addr;
  logic [31:0]               mem_wdata;
  logic [3:0]                mem_wstrb;
  logic [31:0]               mem_rdata;
  logic                      mem_ready;
  logic [7:0]                led;
  logic                      spi_sck;
  logic                      spi_mosi;
  logic                      spi_miso;
  logic [`SPI_CS_LINES-1:0]  spi_cs_n;
  logic [11:0]               drv_en_n;
  logic                      step;
  logic                      dir;

  integer                   seed;
  int                       cycles;
  logic [`SPI_CS_LINES-1:0] exp_cs_n;
  logic                     cs_seen;
  int                       sck_rises;
  logic                     sck_prev;
  logic                     exp_dir;
  int                       exp_gap;
  int                       exp_high;
  int                       step_edges;
  int                       gap_cnt;
  int                       high_len;
  logic                     step_prev;

  stepper_top UUT (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .led       (led),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .spi_cs_n  (spi_cs_n),
    .drv_en_n  (drv_en_n),
    .step      (step),
    .dir       (dir)
  );

  // loopback makes every received frame equal the sent one
  assign spi_miso = spi_mosi;

  always #2 clk_in = ~clk_in;

  task automatic abort_run(input string why);
    $display("Errors found");
    $fatal(1, why);
  endtask

  task automatic check_equal(input string name, input logic [39:0] exp,
                             input logic [39:0] got);
    assert (got === exp)
    else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, got);
      abort_run("value mismatch");
    end
  endtask

  task automatic bus_access(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk_in);
    #1;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    @(negedge clk_in);
    while (!mem_ready && waited < 8) begin
      @(negedge clk_in);
      waited++;
    end
    if (!mem_ready) begin
      abort_run("mem_ready never came for a bus request");
    end
    rdata = mem_rdata;
    @(posedge clk_in);
    #1;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(addr, data, 4'hF, unused);
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  task automatic read_check(input string name, input logic [7:0] addr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    bus_read(addr, rd);
    check_equal(name, exp, rd);
  endtask

  // one frame with send cleared right after the start
  task automatic spi_loopback(input cs_sel_t idx);
    logic [39:0] frame;
    logic [31:0] rd;
    int          polls;
    frame[39:32] = $random(seed);
    frame[31:0]  = $random(seed);
    exp_cs_n = '1;
    if (idx < `SPI_CS_LINES) begin
      exp_cs_n[idx] = 1'b0;
    end
    cs_seen   = 1'b0;
    sck_rises = 0;
    bus_write(reg_spi_tx_upper, {24'h0, frame[39:32]});
    bus_write(reg_spi_tx_lower, frame[31:0]);
    bus_write(reg_spi_config, {27'h0, idx, 1'b1});
    bus_write(reg_spi_config, {27'h0, idx, 1'b0});
    bus_read(reg_spi_status, rd);
    check_equal("spi status during frame", 40'd0, {39'd0, rd[0]});
    polls = 0;
    while (!rd[0] && polls < max_polls) begin
      bus_read(reg_spi_status, rd);
      polls++;
    end
    if (!rd[0]) begin
      abort_run("the SPI frame never finished");
    end
    check_equal("spi chip select used", (idx < `SPI_CS_LINES), cs_seen);
    check_equal("spi sck rising edges", `SPI_FRAME_BITS, sck_rises);
    read_check("spi rx upper", reg_spi_rx_upper, {24'h0, frame[39:32]});
    read_check("spi rx lower", reg_spi_rx_lower, frame[31:0]);
  endtask

  task automatic step_run(input int count, input int period, input logic run_dir);
    logic [31:0] rd;
    int          polls;
    exp_gap    = (period < `STEP_PERIOD_MIN) ? `STEP_PERIOD_MIN : period;
    exp_high   = (exp_gap / 2 < 1) ? 1 : exp_gap / 2;
    exp_dir    = run_dir;
    step_edges = 0;
    bus_write(reg_step_count, count);
    bus_write(reg_step_period, period);
    bus_write(reg_step_control, {30'h0, run_dir, 1'b1});
    rd = '0;
    polls = 0;
    while (!rd[0] && polls < max_polls) begin
      bus_read(reg_step_status, rd);
      polls++;
    end
    if (!rd[0]) begin
      abort_run("the step run never reported done");
    end
    check_equal("step pulse count", count, step_edges);
    check_equal("step dir", run_dir, dir);
    bus_write(reg_step_control, {30'h0, run_dir, 1'b0});
    read_check("step done cleared", reg_step_status, 32'h0);
  endtask

  // step timing and SCK edges sampled on the falling clock
  always @(negedge clk_in) begin
    if (step && !step_prev) begin
      if (step_edges != 0) begin
        check_equal("step period", exp_gap, gap_cnt);
      end
      step_edges = step_edges + 1;
      gap_cnt = 1;
      high_len = 1;
    end else begin
      gap_cnt = gap_cnt + 1;
      if (step) begin
        high_len = high_len + 1;
      end
      if (!step && step_prev) begin
        check_equal("step high time", exp_high, high_len);
      end
    end
    if (spi_cs_n != '1) begin
      cs_seen = 1'b1;
    end
    if (spi_sck && !sck_prev) begin
      sck_rises = sck_rises + 1;
      check_equal("spi chip select at sck rise", exp_cs_n, spi_cs_n);
    end
    sck_prev  = spi_sck;
    step_prev = step;
  end

  always @(posedge clk_in) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      abort_run("timeout, the tests did not finish");
    end
  end

  // only the addressed chip select may be low
  assert property (@(posedge clk_in) disable iff (!arst_n)
    (spi_cs_n == '1) || (spi_cs_n == exp_cs_n))
    else begin
      $display("[FAIL] spi chip select expected %h actual %h", exp_cs_n, spi_cs_n);
      abort_run("wrong chip select low");
    end

  assert property (@(posedge clk_in) disable iff (!arst_n) step |-> (dir == exp_dir))
    else begin
      $display("[FAIL] dir during run expected %h actual %h", exp_dir, dir);
      abort_run("dir changed during a step run");
    end

  initial begin
    logic [31:0] word;
    logic [31:0] rd;
    logic [11:0] en_exp;
    seed       = 83;
    cycles     = 0;
    clk_in     = 1'b0;
    arst_n     = 1'b0;
    mem_valid  = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = '0;
    exp_cs_n   = '1;
    cs_seen    = 1'b0;
    sck_rises  = 0;
    sck_prev   = 1'b0;
    exp_dir    = 1'b0;
    exp_gap    = `STEP_PERIOD_MIN;
    exp_high   = `STEP_PERIOD_MIN / 2;
    step_edges = 0;
    gap_cnt    = 0;
    high_len   = 0;
    step_prev  = 1'b0;

    repeat (8) @(negedge clk_in);
    check_equal("reset mem_ready", 1'b0, mem_ready);
    check_equal("reset spi_sck", 1'b0, spi_sck);
    check_equal("reset spi_cs_n", 12'hFFF, spi_cs_n);
    check_equal("reset step", 1'b0, step);
    check_equal("reset drv_en_n", 12'hFFF, drv_en_n);
    check_equal("reset led", 8'h00, led);
    repeat (8) @(posedge clk_in);
    #1;
    arst_n = 1'b1;
    read_check("reset spi ready", reg_spi_status, 32'h1);
    read_check("reset step done", reg_step_status, 32'h0);

    // register readback masked to width
    repeat (3) begin
      word = $random(seed);
      bus_write(reg_leds, word);
      read_check("leds readback", reg_leds, {24'h0, word[7:0]});
      check_equal("led pins", word[7:0], led);
      word = $random(seed);
      bus_write(reg_spi_tx_lower, word);
      read_check("spi tx lower readback", reg_spi_tx_lower, word);
      word = $random(seed);
      bus_write(reg_spi_tx_upper, word);
      read_check("spi tx upper readback", reg_spi_tx_upper, {24'h0, word[7:0]});
      word = $random(seed);
      bus_write(reg_step_count, word);
      read_check("step count readback", reg_step_count, word);
      word = $random(seed);
      bus_write(reg_step_period, word);
      read_check("step period readback", reg_step_period, word);
    end

    word = $random(seed);
    en_exp = ~word[11:0];
    bus_write(reg_motor_enable, word);
    check_equal("drv_en_n pins", en_exp, drv_en_n);
    read_check("motor enable readback", reg_motor_enable, {20'h0, word[11:0]});

    spi_loopback(4'd0);
    spi_loopback(4'd5);
    spi_loopback(4'd11);
    spi_loopback(4'd14);

    // unmapped offsets and read-only words
    read_check("unmapped 0x30", 8'h30, 32'h0);
    read_check("unmapped 0x80", 8'h80, 32'h0);
    read_check("unmapped 0xfc", 8'hFC, 32'h0);
    bus_write(8'h34, $random(seed));
    read_check("unmapped 0x34 after write", 8'h34, 32'h0);
    bus_read(reg_spi_rx_lower, rd);
    bus_write(reg_spi_rx_lower, ~rd);
    read_check("spi rx lower write ignored", reg_spi_rx_lower, rd);
    bus_write(reg_step_status, 32'hFFFF_FFFF);
    read_check("step status write ignored", reg_step_status, 32'h0);

    step_run(7, 10, 1'b1);
    step_run(3, 2, 1'b0);
    step_run(0, 10, 1'b1);

    $display("No errors");
    $finish;
  end

endmodule

// File: hw/stepper_top.sv
/* stepper_top: stepper peripheral subsystem, register bus in and
   SPI, driver enable and step/dir pins out */
`include "stepper_cfg.svh"

module stepper_top (
  input  logic                      clk_in,
  input  logic                      arst_n,
  input  logic                      mem_valid,
  input  logic [`BUS_ADDR_BITS-1:0] mem_addr,
  input  logic [31:0]               mem_wdata,
  input  logic [3:0]                mem_wstrb,
  output logic [31:0]               mem_rdata,
  output logic                      mem_ready,
  output logic [7:0]                led,
  output logic                      spi_sck,
  output logic                      spi_mosi,
  input  logic                      spi_miso,
  output logic [`SPI_CS_LINES-1:0]  spi_cs_n,
  output logic [11:0]               drv_en_n,
  output logic                      step,
  output logic                      dir
);

  logic [11:0] motor_enable;

  spi_ctrl_if  spi_ctrl ();
  step_ctrl_if step_ctrl ();

  periph_regs regs (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .mem_valid    (mem_valid),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wstrb    (mem_wstrb),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .leds         (led),
    .motor_enable (motor_enable),
    .spi          (spi_ctrl.regs),
    .step         (step_ctrl.regs)
  );

  spi_master spi_engine (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .ctrl   (spi_ctrl.master),
    .sck    (spi_sck),
    .mosi   (spi_mosi),
    .miso   (spi_miso),
    .cs_n   (spi_cs_n)
  );

  step_generator step_gen (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .ctrl   (step_ctrl.gen),
    .step   (step),
    .dir    (dir)
  );

  // driver enables are active low on the board
  assign drv_en_n = ~motor_enable;

endmodule

// File: hw/step_generator.sv
/* step_generator: emits a counted train of step pulses at a fixed period
   and raises done when the run is over */
`include "stepper_cfg.svh"

module step_generator (
  input  logic     clk_in,
  input  logic     arst_n,
  step_ctrl_if.gen ctrl,
  output logic     step,
  output logic     dir
);
  import stepper_pkg::*;

  logic        en_q;
  logic        start;
  logic        running;
  step_count_t period_c;
  step_count_t period_q;
  step_count_t high_from;
  step_count_t cyc_q;
  step_count_t steps_q;

  assign start = ctrl.enable && !en_q && !ctrl.done;

  // short periods are stretched to the minimum
  assign period_c = (ctrl.period < `STEP_PERIOD_MIN) ?
                    step_count_t'(`STEP_PERIOD_MIN) : ctrl.period;

  // cyc_q counts down, so the high half sits at the top of the range
  assign high_from = period_q - (period_q >> 1);
  assign step      = running && (cyc_q >= high_from);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      en_q      <= 1'b0;
      running   <= 1'b0;
      ctrl.done <= 1'b0;
      dir       <= 1'b0;
      period_q  <= '0;
      cyc_q     <= '0;
      steps_q   <= '0;
    end else begin
      en_q <= ctrl.enable;
      if (!ctrl.enable) begin
        // dropping enable aborts a run and clears done
        running   <= 1'b0;
        ctrl.done <= 1'b0;
      end else if (start) begin
        dir       <= ctrl.dir;
        period_q  <= period_c;
        cyc_q     <= period_c - 1'b1;
        steps_q   <= ctrl.count;
        running   <= (ctrl.count != '0);
        ctrl.done <= (ctrl.count == '0);
      end else if (running) begin
        if (cyc_q == '0) begin
          cyc_q   <= period_q - 1'b1;
          steps_q <= steps_q - 1'b1;
          if (steps_q == step_count_t'(1)) begin
            running   <= 1'b0;
            ctrl.done <= 1'b1;
          end
        end else begin
          cyc_q <= cyc_q - 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk_in) disable iff (!arst_n) step |-> !ctrl.done)
    else $error("step pulse after the run finished");

endmodule

// File: hw/spi_master.sv
/* spi_master: mode 0 SPI engine, shifts one frame out MSB first and
   shifts MISO back into the same register, one chip select held low */
`include "stepper_cfg.svh"

module spi_master (
  input  logic                     clk_in,
  input  logic                     arst_n,
  spi_ctrl_if.master               ctrl,
  output logic                     sck,
  output logic                     mosi,
  input  logic                     miso,
  output logic [`SPI_CS_LINES-1:0] cs_n
);
  import stepper_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);
  localparam int BIT_W = $clog2(`SPI_FRAME_BITS);

  logic [DIV_W-1:0]           div_cnt;
  logic [BIT_W-1:0]           bit_cnt;
  logic                       last_q;
  logic                       start;
  logic                       tick;
  logic                       sck_rise;
  logic                       sck_fall;
  logic [`SPI_FRAME_BITS-1:0] shift_q;
  cs_sel_t                    cs_q;
  logic                       miso_q;

  assign start    = ctrl.ready && ctrl.send;
  // half period elapsed, SCK toggles on this edge
  assign tick     = !ctrl.ready && !last_q && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign sck_rise = tick && !sck;
  assign sck_fall = tick && sck;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      ctrl.ready <= 1'b1;
      sck        <= 1'b0;
      last_q     <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
    end else if (start) begin
      ctrl.ready <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
    end else if (last_q) begin
      // one cycle after the last falling edge
      last_q     <= 1'b0;
      ctrl.ready <= 1'b1;
    end else if (!ctrl.ready) begin
      if (tick) begin
        div_cnt <= '0;
        sck     <= !sck;
        if (sck_fall) begin
          bit_cnt <= bit_cnt + 1'b1;
          last_q  <= (bit_cnt == BIT_W'(`SPI_FRAME_BITS - 1));
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // sample on rising, shift on falling
  always_ff @(posedge clk_in) begin
    if (start) begin
      shift_q <= ctrl.frame;
      cs_q    <= ctrl.cs_sel;
    end else if (sck_fall) begin
      shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], miso_q};
    end
    if (sck_rise) begin
      miso_q <= miso;
    end
    if (last_q) begin
      ctrl.rx_frame <= shift_q;
    end
  end

  assign mosi = !ctrl.ready && shift_q[`SPI_FRAME_BITS-1];

  // out of range index leaves every line high
  always_comb begin
    cs_n = '1;
    if (!ctrl.ready && (cs_q < `SPI_CS_LINES)) begin
      cs_n[cs_q] = 1'b0;
    end
  end

  assert property (@(posedge clk_in) disable iff (!arst_n) $onehot0(~cs_n))
    else $error("more than one chip select low");

  assert property (@(posedge clk_in) disable iff (!arst_n) ctrl.ready |-> !sck)
    else $error("sck high while the SPI master is idle");

endmodule

// File: hw/periph_regs.sv
/* periph_regs: valid/ready bus slave for the stepper peripherals
   decodes word offsets, holds the control registers and muxes read data */
`include "stepper_cfg.svh"

module periph_regs (
  input  logic                      clk_in,
  input  logic                      arst_n,
  input  logic                      mem_valid,
  input  logic [`BUS_ADDR_BITS-1:0] mem_addr,
  input  logic [31:0]               mem_wdata,
  input  logic [3:0]                mem_wstrb,
  output logic [31:0]               mem_rdata,
  output logic                      mem_ready,
  output logic [7:0]                leds,
  output logic [11:0]               motor_enable,
  spi_ctrl_if.regs                  spi,
  step_ctrl_if.regs                 step
);
  import stepper_pkg::*;

  reg_addr_e   reg_off;
  logic        access;
  logic        wr_en;
  logic [7:0]  tx_upper_q;
  logic [31:0] tx_lower_q;
  logic        send_q;
  cs_sel_t     cs_sel_q;
  step_count_t step_count_q;
  step_count_t step_period_q;
  logic        step_en_q;
  logic        step_dir_q;

  // word decode, byte lane bits ignored
  assign reg_off = reg_addr_e'({mem_addr[`BUS_ADDR_BITS-1:2], 2'b00});

  // a request is taken once, in the cycle before the ready pulse
  assign access = mem_valid && !mem_ready;
  assign wr_en  = access && (mem_wstrb != 4'b0000);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= access;
    end
  end

  // control bits
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      leds         <= '0;
      motor_enable <= '0;
      send_q       <= 1'b0;
      cs_sel_q     <= '0;
      step_en_q    <= 1'b0;
      step_dir_q   <= 1'b0;
    end else if (wr_en) begin
      case (reg_off)
        reg_leds:         leds <= mem_wdata[7:0];
        reg_motor_enable: motor_enable <= mem_wdata[11:0];
        reg_spi_config: begin
          send_q   <= mem_wdata[0];
          cs_sel_q <= mem_wdata[4:1];
        end
        reg_step_control: begin
          step_en_q  <= mem_wdata[0];
          step_dir_q <= mem_wdata[1];
        end
        default: ;
      endcase
    end
  end

  // data words, only sampled by the engines at a start
  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      case (reg_off)
        reg_spi_tx_upper: tx_upper_q <= mem_wdata[7:0];
        reg_spi_tx_lower: tx_lower_q <= mem_wdata;
        reg_step_count:   step_count_q <= mem_wdata;
        reg_step_period:  step_period_q <= mem_wdata;
        default: ;
      endcase
    end
  end

  // read mux, rx and status words are read-only
  always_comb begin
    mem_rdata = '0;
    case (reg_off)
      reg_leds:         mem_rdata[7:0] = leds;
      reg_spi_tx_upper: mem_rdata[7:0] = tx_upper_q;
      reg_spi_tx_lower: mem_rdata = tx_lower_q;
      reg_spi_rx_upper: mem_rdata[7:0] = spi.rx_frame[4];
      reg_spi_rx_lower: mem_rdata = spi.rx_frame[3:0];
      reg_spi_config:   mem_rdata[4:0] = {cs_sel_q, send_q};
      reg_spi_status:   mem_rdata[0] = spi.ready;
      reg_motor_enable: mem_rdata[11:0] = motor_enable;
      reg_step_count:   mem_rdata = step_count_q;
      reg_step_period:  mem_rdata = step_period_q;
      reg_step_control: mem_rdata[1:0] = {step_dir_q, step_en_q};
      reg_step_status:  mem_rdata[0] = step.done;
      default:          mem_rdata = '0;
    endcase
  end

  assign spi.frame  = {tx_upper_q, tx_lower_q};
  assign spi.cs_sel = cs_sel_q;
  assign spi.send   = send_q;

  assign step.enable = step_en_q;
  assign step.dir    = step_dir_q;
  assign step.count  = step_count_q;
  assign step.period = step_period_q;

  // one ready per request, the master drops valid before the next transfer
  assert property (@(posedge clk_in) disable iff (!arst_n) mem_ready |=> !mem_ready)
    else $error("mem_ready high in two consecutive cycles");

endmodule

// File: hw/step_ctrl_if.sv
/* step_ctrl_if: run parameters and completion flag for the step generator */
interface step_ctrl_if;
  import stepper_pkg::*;

  logic        enable;
  logic        dir;
  step_count_t count;
  step_count_t period;
  logic        done;

  modport regs (
    output enable, dir, count, period,
    input  done
  );

  modport gen (
    input  enable, dir, count, period,
    output done
  );
endinterface

// File: hw/spi_ctrl_if.sv
/* spi_ctrl_if: request and status lines between the register block and the SPI master */
interface spi_ctrl_if;
  import stepper_pkg::*;

  spi_frame_t frame;
  cs_sel_t    cs_sel;
  // level, frames repeat while it stays high
  logic       send;
  spi_frame_t rx_frame;
  logic       ready;

  modport regs (
    output frame, cs_sel, send,
    input  rx_frame, ready
  );

  modport master (
    input  frame, cs_sel, send,
    output rx_frame, ready
  );
endinterface

// File: hw/stepper_pkg.sv
/* stepper_pkg: register map and payload types shared by the stepper peripherals */
`include "stepper_cfg.svh"

package stepper_pkg;

  // byte offsets of the 32-bit registers
  typedef enum logic [`BUS_ADDR_BITS-1:0] {
    reg_leds         = 'h00,
    reg_spi_tx_upper = 'h04,
    reg_spi_tx_lower = 'h08,
    reg_spi_rx_upper = 'h0C,
    reg_spi_rx_lower = 'h10,
    reg_spi_config   = 'h14,
    reg_spi_status   = 'h18,
    reg_motor_enable = 'h1C,
    reg_step_count   = 'h20,
    reg_step_period  = 'h24,
    reg_step_control = 'h28,
    reg_step_status  = 'h2C
  } reg_addr_e;

  // one SPI frame, byte 4 is the upper register
  typedef logic [`SPI_FRAME_BITS/8-1:0][7:0] spi_frame_t;

  // index 12 and above selects no line
  typedef logic [3:0] cs_sel_t;

  typedef logic [31:0] step_count_t;

endpackage

// File: hw/stepper_cfg.svh
/* stepper configuration
   build-time sizes for the SPI engine, the register bus and the step generator */
`ifndef STEPPER_CFG_SVH
`define STEPPER_CFG_SVH

// bits per SPI transfer, a whole number of bytes
`define SPI_FRAME_BITS 40

// chip-select outputs on the board connector
`define SPI_CS_LINES 12

// clk_in cycles per SCK half period
`define SPI_CLK_DIV 4

// byte address width seen by the register block
`define BUS_ADDR_BITS 8

// shortest step period in clk_in cycles
// keeps the high half of a pulse at two cycles or more
`define STEP_PERIOD_MIN 4

`endif
